/* filelist.f */
logic/ntt_pp_pkg.sv
logic/pp_beat_if.sv
logic/pp_mod_mult.sv
logic/pp_lane.sv
logic/pp_ctrl.sv
logic/pp_route.sv
logic/ntt_pp_top.sv
sim/tb_ntt_pp.sv

/* Bender.yml */
package:
  name: ntt_pp

sources:
  - logic/ntt_pp_pkg.sv
  - logic/pp_beat_if.sv
  - logic/pp_mod_mult.sv
  - logic/pp_lane.sv
  - logic/pp_ctrl.sv
  - logic/pp_route.sv
  - logic/ntt_pp_top.sv
  - target: simulation
    files:
      - sim/tb_ntt_pp.sv

/* sim/tb_ntt_pp.sv */
// Table-driven testbench for the NTT post-processing block with reference model
`timescale 1ns/1ps

module tb_ntt_pp;

  localparam int OP_W      = 16;
  localparam int LANES     = 4;
  localparam longint MOD   = 65521;
  localparam int N_ROWS    = 6;
  localparam int MAX_BEATS = 6;
  localparam int MAX_CYC   = 512;
  localparam int RST_CYC   = 8;
  localparam int WD_CYC    = N_ROWS * (MAX_BEATS + 20) + RST_CYC;
  localparam int K_IDLE    = 0;
  localparam int K_PASS    = 1;
  localparam int K_TWD     = 2;
  localparam int K_BSK     = 3;
  localparam int K_MIX     = 4;

  logic clk;
  logic rst;
  logic [LANES-1:0][OP_W-1:0] in_data, twd, bsk;
  logic in_avail, sob, eob, sol, eol, sos, eos, ntt_bwd, last_stg;
  logic [ntt_pp_pkg::PBS_ID_W-1:0] pbs_id;
  logic [LANES-1:0] twd_vld, twd_rdy, bsk_vld, bsk_rdy;
  logic [LANES-1:0][OP_W-1:0] pp_rsntw_data, pp_lsntw_fwd_data, pp_lsntw_bwd_data;
  logic pp_rsntw_sob, pp_rsntw_eob, pp_rsntw_sol, pp_rsntw_eol, pp_rsntw_sos, pp_rsntw_eos;
  logic pp_lsntw_fwd_sob, pp_lsntw_fwd_eob, pp_lsntw_fwd_sol, pp_lsntw_fwd_eol;
  logic pp_lsntw_fwd_sos, pp_lsntw_fwd_eos;
  logic pp_lsntw_bwd_sob, pp_lsntw_bwd_eob, pp_lsntw_bwd_sol, pp_lsntw_bwd_eol;
  logic pp_lsntw_bwd_sos, pp_lsntw_bwd_eos;
  logic [ntt_pp_pkg::PBS_ID_W-1:0] pp_rsntw_pbs_id, pp_lsntw_fwd_pbs_id, pp_lsntw_bwd_pbs_id;
  logic pp_rsntw_avail, pp_lsntw_fwd_avail, pp_lsntw_bwd_avail, pp_error;

  // ------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------
  string                      row_name  [N_ROWS];
  int                         row_kind  [N_ROWS];
  int                         row_beats [N_ROWS];
  int                         row_hold  [N_ROWS];
  logic [LANES-1:0][OP_W-1:0] row_data  [N_ROWS][MAX_BEATS];
  logic [LANES-1:0][OP_W-1:0] row_twd   [N_ROWS][MAX_BEATS];
  logic [LANES-1:0][OP_W-1:0] row_bsk   [N_ROWS][MAX_BEATS];

  // Expected outputs indexed by negedge count, dst 1 regular, 2 forward, 3 backward
  int                              exp_dst  [MAX_CYC];
  logic [LANES-1:0][OP_W-1:0]      exp_data [MAX_CYC];
  logic [5:0]                      exp_strb [MAX_CYC];
  logic [ntt_pp_pkg::PBS_ID_W-1:0] exp_pbs  [MAX_CYC];
  logic                            err_exp  [MAX_CYC];
  // Factor ready per cycle, twiddle in bit 1 and key in bit 0
  logic [1:0]                      exp_rdy  [MAX_CYC];
  logic [OP_W-1:0]                 acc_model [LANES];

  integer seed;
  int     neg_cnt;
  int     err_cnt;
  int     tests_pass;
  int     tests_fail;
  string  cur_name;

  ntt_pp_top ntt_pp_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  initial begin
    #(WD_CYC * 10);
    $display("Watchdog expired before the last test finished");
    $display("tests failed");
    $finish;
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic logic [OP_W-1:0] mul_mod(input longint a, input longint b);
    return OP_W'((a * b) % MOD);
  endfunction

  function automatic logic [OP_W-1:0] add_mod(input longint a, input longint b);
    longint s;
    s = a + b;
    if (s >= MOD) begin
      s = s - MOD;
    end
    return OP_W'(s);
  endfunction

  function automatic ntt_pp_pkg::pp_op_e beat_op(input int kind, input int b);
    ntt_pp_pkg::pp_op_e mix [MAX_BEATS];
    mix = '{ntt_pp_pkg::PP_PASS, ntt_pp_pkg::PP_TWD_MULT, ntt_pp_pkg::PP_BSK_MAC,
            ntt_pp_pkg::PP_TWD_MULT, ntt_pp_pkg::PP_BSK_MAC, ntt_pp_pkg::PP_PASS};
    case (kind)
      K_TWD:   return ntt_pp_pkg::PP_TWD_MULT;
      K_BSK:   return ntt_pp_pkg::PP_BSK_MAC;
      K_MIX:   return mix[b];
      default: return ntt_pp_pkg::PP_PASS;
    endcase
  endfunction

  // Order is sob, eob, sol, eol, sos, eos
  function automatic logic [5:0] beat_strobes(input int kind, input int b, input int n);
    logic f, l, s, e;
    f = (b == 0);
    l = (b == n - 1);
    s = (kind == K_MIX) ? (b == 2) : f;
    e = (kind == K_MIX) ? (b == 4) : l;
    return {f, l, s, e, f, l};
  endfunction

  task automatic build_table();
    row_name  = '{"idle_after_reset", "regular_pass", "bwd_twiddle",
                  "fwd_bsk_three_levels", "mixed_back_to_back", "twd_valid_withheld"};
    row_kind  = '{K_IDLE, K_PASS, K_TWD, K_BSK, K_MIX, K_TWD};
    row_beats = '{4, 2, 2, 3, 6, 1};
    row_hold  = '{-1, -1, -1, -1, -1, 1};
    for (int r = 0; r < N_ROWS; r++) begin
      for (int b = 0; b < MAX_BEATS; b++) begin
        for (int l = 0; l < LANES; l++) begin
          row_data[r][b][l] = OP_W'($unsigned($random(seed)) % MOD);
          row_twd[r][b][l]  = OP_W'($unsigned($random(seed)) % MOD);
          row_bsk[r][b][l]  = OP_W'($unsigned($random(seed)) % MOD);
        end
      end
    end
  endtask

  // ------------------------------------------------------------
  // Driver
  // ------------------------------------------------------------
  task automatic drive_beat(input int r, input int b);
    ntt_pp_pkg::pp_op_e         op;
    logic [5:0]                 strb;
    logic [LANES-1:0]           vld_mask;
    logic [LANES-1:0][OP_W-1:0] res;
    logic [OP_W-1:0]            prod;
    int                         slot;
    op       = beat_op(row_kind[r], b);
    strb     = beat_strobes(row_kind[r], b, row_beats[r]);
    slot     = neg_cnt + 5;
    vld_mask = '1;
    if (row_hold[r] >= 0) begin
      vld_mask[row_hold[r]] = 1'b0;
    end
    in_avail <= (row_kind[r] != K_IDLE);
    in_data  <= row_data[r][b];
    twd      <= row_twd[r][b];
    bsk      <= row_bsk[r][b];
    {sob, eob, sol, eol, sos, eos} <= strb;
    pbs_id   <= ntt_pp_pkg::PBS_ID_W'(r + 5);
    last_stg <= (row_kind[r] != K_IDLE) && (op != ntt_pp_pkg::PP_PASS);
    ntt_bwd  <= (op == ntt_pp_pkg::PP_TWD_MULT);
    twd_vld  <= (op == ntt_pp_pkg::PP_TWD_MULT) ? vld_mask : '0;
    bsk_vld  <= (op == ntt_pp_pkg::PP_BSK_MAC) ? '1 : '0;
    if (row_kind[r] != K_IDLE) begin
      exp_rdy[neg_cnt] = {op == ntt_pp_pkg::PP_TWD_MULT, op == ntt_pp_pkg::PP_BSK_MAC};
      for (int l = 0; l < LANES; l++) begin
        case (op)
          ntt_pp_pkg::PP_PASS: res[l] = row_data[r][b][l];
          ntt_pp_pkg::PP_TWD_MULT: begin
            prod   = (l == row_hold[r]) ? '0 : row_twd[r][b][l];
            res[l] = mul_mod(row_data[r][b][l], prod);
          end
          default: begin
            prod         = mul_mod(row_data[r][b][l], row_bsk[r][b][l]);
            acc_model[l] = strb[3] ? prod : add_mod(acc_model[l], prod);
            res[l]       = acc_model[l];
          end
        endcase
      end
      if (op == ntt_pp_pkg::PP_PASS) begin
        exp_dst[slot] = 1;
      end else if (op == ntt_pp_pkg::PP_TWD_MULT) begin
        exp_dst[slot] = 3;
      end else if (strb[2]) begin
        exp_dst[slot] = 2;
      end
      exp_data[slot] = res;
      exp_strb[slot] = strb;
      exp_pbs[slot]  = ntt_pp_pkg::PBS_ID_W'(r + 5);
      if (op == ntt_pp_pkg::PP_TWD_MULT && row_hold[r] >= 0) begin
        err_exp[neg_cnt + 2] = 1'b1;
      end
    end
  endtask

  task automatic go_idle();
    in_avail <= 1'b0;
    {sob, eob, sol, eol, sos, eos} <= '0;
    last_stg <= 1'b0;
    ntt_bwd  <= 1'b0;
    twd_vld  <= '0;
    bsk_vld  <= '0;
  endtask

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_data(input string name, input logic [LANES-1:0][OP_W-1:0] exp,
                            input logic [LANES-1:0][OP_W-1:0] act);
    for (int l = 0; l < LANES; l++) begin
      if (act[l] !== exp[l]) begin
        $display("ERROR %s: lane %0d data expected %h actual %h", name, l, exp[l], act[l]);
        err_cnt++;
      end
    end
  endtask

  task automatic check_frame(input string name, input logic [5:0] exp_s, input logic [5:0] act_s,
                             input logic [ntt_pp_pkg::PBS_ID_W-1:0] exp_p,
                             input logic [ntt_pp_pkg::PBS_ID_W-1:0] act_p);
    if (act_s !== exp_s || act_p !== exp_p) begin
      $display("ERROR %s: strobes/pbs_id expected %b/%h actual %b/%h",
               name, exp_s, exp_p, act_s, act_p);
      err_cnt++;
    end
  endtask

  task automatic check_error(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: pp_error expected %b actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flags(input string name, input string what,
                             input logic [LANES-1:0] exp, input logic [LANES-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %b actual %b", name, what, exp, act);
      err_cnt++;
    end
  endtask

  // ------------------------------------------------------------
  // Monitor, samples at negedge where outputs are stable
  // ------------------------------------------------------------
  always @(negedge clk) begin : monitor
    int c;
    c = neg_cnt;
    if (!rst && c < MAX_CYC) begin
      check_flags(cur_name, "avail rs/fwd/bwd",
                  {1'b0, exp_dst[c] == 3, exp_dst[c] == 2, exp_dst[c] == 1},
                  {1'b0, pp_lsntw_bwd_avail, pp_lsntw_fwd_avail, pp_rsntw_avail});
      check_flags(cur_name, "twd_rdy", {LANES{exp_rdy[c][1]}}, twd_rdy);
      check_flags(cur_name, "bsk_rdy", {LANES{exp_rdy[c][0]}}, bsk_rdy);
      check_error(cur_name, err_exp[c], pp_error);
      if (exp_dst[c] == 1) begin
        check_data(cur_name, exp_data[c], pp_rsntw_data);
        check_frame(cur_name, exp_strb[c], {pp_rsntw_sob, pp_rsntw_eob, pp_rsntw_sol,
                    pp_rsntw_eol, pp_rsntw_sos, pp_rsntw_eos}, exp_pbs[c], pp_rsntw_pbs_id);
      end else if (exp_dst[c] == 2) begin
        check_data(cur_name, exp_data[c], pp_lsntw_fwd_data);
        check_frame(cur_name, exp_strb[c], {pp_lsntw_fwd_sob, pp_lsntw_fwd_eob,
                    pp_lsntw_fwd_sol, pp_lsntw_fwd_eol, pp_lsntw_fwd_sos, pp_lsntw_fwd_eos},
                    exp_pbs[c], pp_lsntw_fwd_pbs_id);
      end else if (exp_dst[c] == 3) begin
        check_data(cur_name, exp_data[c], pp_lsntw_bwd_data);
        check_frame(cur_name, exp_strb[c], {pp_lsntw_bwd_sob, pp_lsntw_bwd_eob,
                    pp_lsntw_bwd_sol, pp_lsntw_bwd_eol, pp_lsntw_bwd_sos, pp_lsntw_bwd_eos},
                    exp_pbs[c], pp_lsntw_bwd_pbs_id);
      end
    end
    neg_cnt++;
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int err_start;
    int last_due;
    seed     = 75;
    neg_cnt  = 0;
    err_cnt  = 0;
    cur_name = "reset";
    rst      <= 1'b1;
    in_data  <= '0;
    twd      <= '0;
    bsk      <= '0;
    pbs_id   <= '0;
    go_idle();
    for (int c = 0; c < MAX_CYC; c++) begin
      exp_dst[c] = 0;
      err_exp[c] = 1'b0;
      exp_rdy[c] = 2'b00;
    end
    build_table();
    repeat (RST_CYC) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < N_ROWS; r++) begin
      err_start = err_cnt;
      for (int b = 0; b < row_beats[r]; b++) begin
        @(posedge clk);
        cur_name = row_name[r];
        drive_beat(r, b);
      end
      last_due = neg_cnt + 5;
      @(posedge clk);
      go_idle();
      // Latency is fixed, so drain until the last slot was checked
      while (neg_cnt <= last_due) begin
        @(posedge clk);
      end
      if (err_cnt == err_start) begin
        tests_pass++;
        $display("PASS %s", row_name[r]);
      end else begin
        tests_fail++;
        $display("FAIL %s with %0d check errors", row_name[r], err_cnt - err_start);
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
             N_ROWS, tests_pass, tests_fail, err_cnt);
    if (tests_fail == 0 && err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* logic/ntt_pp_top.sv */
// NTT butterfly output post-processing: pass, final twiddle and key matrix product
`timescale 1ns/1ps

module ntt_pp_top #(
  parameter int              OP_W    = 16,
  parameter logic [OP_W-1:0] MOD_NTT = OP_W'(65521),
  parameter int              PSI     = 2,
  parameter int              R       = 2
) (
  input  logic                            clk,
  input  logic                            rst,
  // ------------------------------------------------------------
  // Butterfly core output
  // ------------------------------------------------------------
  input  logic [PSI*R-1:0][OP_W-1:0]      in_data,
  input  logic                            in_avail,
  input  logic                            sob,
  input  logic                            eob,
  input  logic                            sol,
  input  logic                            eol,
  input  logic                            sos,
  input  logic                            eos,
  input  logic                            ntt_bwd,
  input  logic                            last_stg,
  input  logic [ntt_pp_pkg::PBS_ID_W-1:0] pbs_id,
  // Factors
  input  logic [PSI*R-1:0][OP_W-1:0]      twd,
  input  logic [PSI*R-1:0]                twd_vld,
  output logic [PSI*R-1:0]                twd_rdy,
  input  logic [PSI*R-1:0][OP_W-1:0]      bsk,
  input  logic [PSI*R-1:0]                bsk_vld,
  output logic [PSI*R-1:0]                bsk_rdy,
  // ------------------------------------------------------------
  // Output streams
  // ------------------------------------------------------------
  output logic [PSI*R-1:0][OP_W-1:0]      pp_rsntw_data,
  output logic                            pp_rsntw_sob,
  output logic                            pp_rsntw_eob,
  output logic                            pp_rsntw_sol,
  output logic                            pp_rsntw_eol,
  output logic                            pp_rsntw_sos,
  output logic                            pp_rsntw_eos,
  output logic [ntt_pp_pkg::PBS_ID_W-1:0] pp_rsntw_pbs_id,
  output logic                            pp_rsntw_avail,
  output logic [PSI*R-1:0][OP_W-1:0]      pp_lsntw_fwd_data,
  output logic                            pp_lsntw_fwd_sob,
  output logic                            pp_lsntw_fwd_eob,
  output logic                            pp_lsntw_fwd_sol,
  output logic                            pp_lsntw_fwd_eol,
  output logic                            pp_lsntw_fwd_sos,
  output logic                            pp_lsntw_fwd_eos,
  output logic [ntt_pp_pkg::PBS_ID_W-1:0] pp_lsntw_fwd_pbs_id,
  output logic                            pp_lsntw_fwd_avail,
  output logic [PSI*R-1:0][OP_W-1:0]      pp_lsntw_bwd_data,
  output logic                            pp_lsntw_bwd_sob,
  output logic                            pp_lsntw_bwd_eob,
  output logic                            pp_lsntw_bwd_sol,
  output logic                            pp_lsntw_bwd_eol,
  output logic                            pp_lsntw_bwd_sos,
  output logic                            pp_lsntw_bwd_eos,
  output logic [ntt_pp_pkg::PBS_ID_W-1:0] pp_lsntw_bwd_pbs_id,
  output logic                            pp_lsntw_bwd_avail,
  output logic                            pp_error
);

  ntt_pp_pkg::pp_op_e         lane_op;
  logic [PSI*R-1:0]           twd_ok;
  logic [PSI*R-1:0]           bsk_ok;
  logic [PSI*R-1:0][OP_W-1:0] lane_result;

  pp_beat_if beat_if ();

  pp_ctrl #(
    .PSI (PSI),
    .R   (R)
  ) ctrl_inst (
    .clk      (clk),
    .rst      (rst),
    .in_avail (in_avail),
    .sob      (sob),
    .eob      (eob),
    .sol      (sol),
    .eol      (eol),
    .sos      (sos),
    .eos      (eos),
    .ntt_bwd  (ntt_bwd),
    .last_stg (last_stg),
    .pbs_id   (pbs_id),
    .twd_vld  (twd_vld),
    .bsk_vld  (bsk_vld),
    .twd_rdy  (twd_rdy),
    .bsk_rdy  (bsk_rdy),
    .lane_op  (lane_op),
    .twd_ok   (twd_ok),
    .bsk_ok   (bsk_ok),
    .pp_error (pp_error),
    .beat     (beat_if.ctrl)
  );

  // One lane per coefficient of the beat
  for (genvar l = 0; l < PSI * R; l++) begin : lane_gen
    pp_lane #(
      .OP_W    (OP_W),
      .MOD_NTT (MOD_NTT)
    ) lane_inst (
      .clk      (clk),
      .rst      (rst),
      .data     (in_data[l]),
      .twd      (twd[l]),
      .bsk      (bsk[l]),
      .op       (lane_op),
      .in_avail (in_avail),
      .sol      (sol),
      .eol      (eol),
      .twd_ok   (twd_ok[l]),
      .bsk_ok   (bsk_ok[l]),
      .result   (lane_result[l])
    );
  end

  pp_route #(
    .OP_W (OP_W),
    .PSI  (PSI),
    .R    (R)
  ) route_inst (
    .clk         (clk),
    .rst         (rst),
    .beat        (beat_if.route),
    .lane_result (lane_result),
    .rs_data     (pp_rsntw_data),
    .rs_sob      (pp_rsntw_sob),
    .rs_eob      (pp_rsntw_eob),
    .rs_sol      (pp_rsntw_sol),
    .rs_eol      (pp_rsntw_eol),
    .rs_sos      (pp_rsntw_sos),
    .rs_eos      (pp_rsntw_eos),
    .rs_pbs_id   (pp_rsntw_pbs_id),
    .rs_avail    (pp_rsntw_avail),
    .fwd_data    (pp_lsntw_fwd_data),
    .fwd_sob     (pp_lsntw_fwd_sob),
    .fwd_eob     (pp_lsntw_fwd_eob),
    .fwd_sol     (pp_lsntw_fwd_sol),
    .fwd_eol     (pp_lsntw_fwd_eol),
    .fwd_sos     (pp_lsntw_fwd_sos),
    .fwd_eos     (pp_lsntw_fwd_eos),
    .fwd_pbs_id  (pp_lsntw_fwd_pbs_id),
    .fwd_avail   (pp_lsntw_fwd_avail),
    .bwd_data    (pp_lsntw_bwd_data),
    .bwd_sob     (pp_lsntw_bwd_sob),
    .bwd_eob     (pp_lsntw_bwd_eob),
    .bwd_sol     (pp_lsntw_bwd_sol),
    .bwd_eol     (pp_lsntw_bwd_eol),
    .bwd_sos     (pp_lsntw_bwd_sos),
    .bwd_eos     (pp_lsntw_bwd_eos),
    .bwd_pbs_id  (pp_lsntw_bwd_pbs_id),
    .bwd_avail   (pp_lsntw_bwd_avail)
  );

endmodule

/* logic/pp_route.sv */
// Output router registering lane results onto regular, forward and backward streams
`timescale 1ns/1ps

module pp_route #(
  parameter int OP_W = 16,
  parameter int PSI  = 2,
  parameter int R    = 2
) (
  input  logic                              clk,
  input  logic                              rst,
  pp_beat_if.route                          beat,
  input  logic [PSI*R-1:0][OP_W-1:0]        lane_result,
  // Regular stage
  output logic [PSI*R-1:0][OP_W-1:0]        rs_data,
  output logic                              rs_sob,
  output logic                              rs_eob,
  output logic                              rs_sol,
  output logic                              rs_eol,
  output logic                              rs_sos,
  output logic                              rs_eos,
  output logic [ntt_pp_pkg::PBS_ID_W-1:0]   rs_pbs_id,
  output logic                              rs_avail,
  // Forward last stage
  output logic [PSI*R-1:0][OP_W-1:0]        fwd_data,
  output logic                              fwd_sob,
  output logic                              fwd_eob,
  output logic                              fwd_sol,
  output logic                              fwd_eol,
  output logic                              fwd_sos,
  output logic                              fwd_eos,
  output logic [ntt_pp_pkg::PBS_ID_W-1:0]   fwd_pbs_id,
  output logic                              fwd_avail,
  // Backward last stage
  output logic [PSI*R-1:0][OP_W-1:0]        bwd_data,
  output logic                              bwd_sob,
  output logic                              bwd_eob,
  output logic                              bwd_sol,
  output logic                              bwd_eol,
  output logic                              bwd_sos,
  output logic                              bwd_eos,
  output logic [ntt_pp_pkg::PBS_ID_W-1:0]   bwd_pbs_id,
  output logic                              bwd_avail
);

  localparam int FR_W = 6 + ntt_pp_pkg::PBS_ID_W;

  // Destination index 0 regular, 1 forward, 2 backward
  logic [2:0]                 dst_hit;
  logic [2:0]                 dst_avail;
  logic [FR_W-1:0]            beat_frame;
  logic [FR_W-1:0]            dst_frame [3];
  logic [PSI*R-1:0][OP_W-1:0] dst_data  [3];

  assign beat_frame = {beat.sob, beat.eob, beat.sol, beat.eol, beat.sos, beat.eos, beat.pbs_id};

  assign dst_hit[0] = beat.avail && beat.op == ntt_pp_pkg::PP_PASS;
  // Key beats leave only once the batch sum is complete
  assign dst_hit[1] = beat.avail && beat.op == ntt_pp_pkg::PP_BSK_MAC && beat.eol;
  assign dst_hit[2] = beat.avail && beat.op == ntt_pp_pkg::PP_TWD_MULT;

  always_ff @(posedge clk) begin
    if (rst) begin
      dst_avail <= '0;
    end else begin
      dst_avail <= dst_hit;
    end
  end

  // Each destination holds its last data and framing
  always_ff @(posedge clk) begin
    for (int d = 0; d < 3; d++) begin
      if (dst_hit[d]) begin
        dst_data[d]  <= lane_result;
        dst_frame[d] <= beat_frame;
      end
    end
  end

  assign rs_data  = dst_data[0];
  assign fwd_data = dst_data[1];
  assign bwd_data = dst_data[2];
  assign {rs_sob, rs_eob, rs_sol, rs_eol, rs_sos, rs_eos, rs_pbs_id} = dst_frame[0];
  assign {fwd_sob, fwd_eob, fwd_sol, fwd_eol, fwd_sos, fwd_eos, fwd_pbs_id} = dst_frame[1];
  assign {bwd_sob, bwd_eob, bwd_sol, bwd_eol, bwd_sos, bwd_eos, bwd_pbs_id} = dst_frame[2];
  assign {bwd_avail, fwd_avail, rs_avail} = dst_avail;

  a_one_dst: assert property (@(posedge clk) disable iff (rst)
    $onehot0({rs_avail, fwd_avail, bwd_avail}));

endmodule

/* logic/pp_ctrl.sv */
// Beat control: op decode, factor handshake, error check and framing delay
`timescale 1ns/1ps

module pp_ctrl #(
  parameter int PSI = 2,
  parameter int R   = 2
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            in_avail,
  input  logic                            sob,
  input  logic                            eob,
  input  logic                            sol,
  input  logic                            eol,
  input  logic                            sos,
  input  logic                            eos,
  input  logic                            ntt_bwd,
  input  logic                            last_stg,
  input  logic [ntt_pp_pkg::PBS_ID_W-1:0] pbs_id,
  input  logic [PSI*R-1:0]                twd_vld,
  input  logic [PSI*R-1:0]                bsk_vld,
  output logic [PSI*R-1:0]                twd_rdy,
  output logic [PSI*R-1:0]                bsk_rdy,
  output ntt_pp_pkg::pp_op_e              lane_op,
  output logic [PSI*R-1:0]                twd_ok,
  output logic [PSI*R-1:0]                bsk_ok,
  output logic                            pp_error,
  pp_beat_if.ctrl                         beat
);

  localparam int N    = PSI * R;
  localparam int DL   = ntt_pp_pkg::PP_LAT;
  // Strobes, pbs_id and op
  localparam int FR_W = 6 + ntt_pp_pkg::PBS_ID_W + 2;

  logic                      missing;
  logic                      err_q;
  logic [DL-1:0]             avail_dl;
  logic [DL-1:0][FR_W-1:0]   frame_dl;
  logic [1:0]                op_bits;

  // ------------------------------------------------------------
  // Op decode and factor handshake
  // ------------------------------------------------------------
  always_comb begin
    if (!last_stg) begin
      lane_op = ntt_pp_pkg::PP_PASS;
    end else if (ntt_bwd) begin
      lane_op = ntt_pp_pkg::PP_TWD_MULT;
    end else begin
      lane_op = ntt_pp_pkg::PP_BSK_MAC;
    end
  end

  assign twd_rdy = {N{in_avail && lane_op == ntt_pp_pkg::PP_TWD_MULT}};
  assign bsk_rdy = {N{in_avail && lane_op == ntt_pp_pkg::PP_BSK_MAC}};

  // Factor actually transferred on this beat
  assign twd_ok  = twd_rdy & twd_vld;
  assign bsk_ok  = bsk_rdy & bsk_vld;
  assign missing = |(twd_rdy & ~twd_vld) || |(bsk_rdy & ~bsk_vld);

  // Error lines up with the registered product
  always_ff @(posedge clk) begin
    if (rst) begin
      err_q    <= 1'b0;
      pp_error <= 1'b0;
    end else begin
      err_q    <= missing;
      pp_error <= err_q;
    end
  end

  // ------------------------------------------------------------
  // Framing delay line
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      avail_dl <= '0;
    end else begin
      avail_dl <= {avail_dl[DL-2:0], in_avail};
    end
  end

  always_ff @(posedge clk) begin
    frame_dl <= {frame_dl[DL-2:0], {sob, eob, sol, eol, sos, eos, pbs_id, lane_op}};
  end

  assign {beat.sob, beat.eob, beat.sol, beat.eol, beat.sos, beat.eos,
          beat.pbs_id, op_bits} = frame_dl[DL-1];
  assign beat.op    = ntt_pp_pkg::pp_op_e'(op_bits);
  assign beat.avail = avail_dl[DL-1];

  a_no_avail_in_rst: assert property (@(posedge clk) rst |-> !in_avail);

  // A factor offered and not yet taken stays offered
  a_twd_held: assert property (@(posedge clk) disable iff (rst)
    |(twd_vld & ~twd_rdy) |=> &(twd_vld | ~$past(twd_vld & ~twd_rdy)));

  a_bsk_held: assert property (@(posedge clk) disable iff (rst)
    |(bsk_vld & ~bsk_rdy) |=> &(bsk_vld | ~$past(bsk_vld & ~bsk_rdy)));

endmodule

/* logic/pp_lane.sv */
// One coefficient lane: pass, twiddle multiply or key multiply-accumulate
`timescale 1ns/1ps

module pp_lane #(
  parameter int              OP_W    = 16,
  parameter logic [OP_W-1:0] MOD_NTT = OP_W'(65521)
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [OP_W-1:0]    data,
  input  logic [OP_W-1:0]    twd,
  input  logic [OP_W-1:0]    bsk,
  input  ntt_pp_pkg::pp_op_e op,
  input  logic               in_avail,
  input  logic               sol,
  input  logic               eol,
  input  logic               twd_ok,
  input  logic               bsk_ok,
  output logic [OP_W-1:0]    result
);

  // Side pipe matches input register plus multiplier stages
  localparam int SR_D = ntt_pp_pkg::PP_LAT - 1;

  logic [OP_W-1:0]    fac;
  logic [OP_W-1:0]    data_q;
  logic [OP_W-1:0]    fac_q;
  logic [OP_W-1:0]    prod;
  logic [OP_W-1:0]    acc_q;
  logic [OP_W-1:0]    acc_next;
  logic [OP_W:0]      acc_sum;
  logic [SR_D-1:0]    avail_sr;
  logic [SR_D-1:0]    sol_sr;
  logic [SR_D-1:0]    eol_sr;
  ntt_pp_pkg::pp_op_e op_sr [SR_D];

  // Multiplier operand, a missing factor reads as zero
  always_comb begin
    case (op)
      ntt_pp_pkg::PP_TWD_MULT: fac = twd_ok ? twd : '0;
      ntt_pp_pkg::PP_BSK_MAC:  fac = bsk_ok ? bsk : '0;
      // Coefficients arrive already reduced below MOD_NTT
      default:                 fac = OP_W'(1);
    endcase
  end

  always_ff @(posedge clk) begin
    data_q <= data;
    fac_q  <= fac;
    sol_sr <= {sol_sr[SR_D-2:0], sol};
    eol_sr <= {eol_sr[SR_D-2:0], eol};
    op_sr[0] <= op;
    for (int i = 1; i < SR_D; i++) begin
      op_sr[i] <= op_sr[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      avail_sr <= '0;
    end else begin
      avail_sr <= {avail_sr[SR_D-2:0], in_avail};
    end
  end

  pp_mod_mult #(
    .OP_W    (OP_W),
    .MOD_NTT (MOD_NTT)
  ) mult_inst (
    .clk (clk),
    .rst (rst),
    .a   (data_q),
    .b   (fac_q),
    .p   (prod)
  );

  // ------------------------------------------------------------
  // Accumulate over the levels of a batch
  // ------------------------------------------------------------
  always_comb begin
    acc_sum = {1'b0, acc_q} + {1'b0, prod};
    if (sol_sr[SR_D-1]) begin
      acc_next = prod;
    end else if (acc_sum >= {1'b0, MOD_NTT}) begin
      acc_next = OP_W'(acc_sum - {1'b0, MOD_NTT});
    end else begin
      acc_next = acc_sum[OP_W-1:0];
    end
  end

  // Cleared after eol so a batch without sol still starts at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      acc_q <= '0;
    end else if (avail_sr[SR_D-1] && op_sr[SR_D-1] == ntt_pp_pkg::PP_BSK_MAC) begin
      acc_q <= eol_sr[SR_D-1] ? '0 : acc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (avail_sr[SR_D-1]) begin
      result <= (op_sr[SR_D-1] == ntt_pp_pkg::PP_BSK_MAC) ? acc_next : prod;
    end
  end

endmodule

/* logic/pp_mod_mult.sv */
// Two-stage pipelined multiplier reducing the product modulo MOD_NTT
`timescale 1ns/1ps

module pp_mod_mult #(
  parameter int              OP_W    = 16,
  parameter logic [OP_W-1:0] MOD_NTT = OP_W'(65521)
) (
  input  logic            clk,
  input  logic            rst,
  input  logic [OP_W-1:0] a,
  input  logic [OP_W-1:0] b,
  output logic [OP_W-1:0] p
);

  logic [2*OP_W-1:0] prod_q;
  logic [2*OP_W-1:0] rem;

  // Remainder of a double-width product by a constant modulus
  assign rem = prod_q % {{OP_W{1'b0}}, MOD_NTT};

  // Stage 1, full product
  always_ff @(posedge clk) begin
    if (rst) begin
      prod_q <= '0;
    end else begin
      prod_q <= a * b;
    end
  end

  // Stage 2, reduction
  always_ff @(posedge clk) begin
    if (rst) begin
      p <= '0;
    end else begin
      p <= rem[OP_W-1:0];
    end
  end

endmodule

/* logic/pp_beat_if.sv */
// Beat framing and operation handed from control to output router
`timescale 1ns/1ps

interface pp_beat_if;

  logic                            sob;
  logic                            eob;
  logic                            sol;
  logic                            eol;
  logic                            sos;
  logic                            eos;
  logic [ntt_pp_pkg::PBS_ID_W-1:0] pbs_id;
  ntt_pp_pkg::pp_op_e              op;
  // Lane results are valid with this strobe
  logic                            avail;

  modport ctrl (
    output sob, eob, sol, eol, sos, eos, pbs_id, op, avail
  );

  modport route (
    input sob, eob, sol, eol, sos, eos, pbs_id, op, avail
  );

endinterface

/* logic/ntt_pp_pkg.sv */
// NTT post-processing shared types and constants
package ntt_pp_pkg;

  // ------------------------------------------------------------
  // Operation applied to one beat
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    PP_PASS     = 2'd0, // Regular stage, data unchanged
    PP_TWD_MULT = 2'd1, // Backward last stage, final twiddle
    PP_BSK_MAC  = 2'd2  // Forward last stage, key multiply-accumulate
  } pp_op_e;

  // ------------------------------------------------------------
  // Timing and widths
  // ------------------------------------------------------------
  // Input avail to lane result
  localparam int PP_LAT = 4;

  // Batch identifier
  localparam int PBS_ID_W = 4;

endpackage
